/* include/trap_config.svh */
// CSR numbers, identity values, interrupt numbers, timer offsets and enable depth.
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// Standard M-mode CSR numbers.
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSTATUSH    12'h310
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344
`define CSR_MVENDORID   12'hf11
`define CSR_MARCHID     12'hf12
`define CSR_MIMPID      12'hf13
`define CSR_MHARTID     12'hf14
`define CSR_MCONFIGPTR  12'hf15

// Identity words.
`define TRAP_MARCHID    32'd37
`define TRAP_MHARTID    32'd0
`define TRAP_MIMPID     32'h0000_0200
// MXL=1 (RV32), extensions A, C, I and M.
`define TRAP_MISA       32'h4000_1105

// Interrupt numbers.
`define TIMER_IRQ       7
`define EXT_IRQ_LO      16

// Cycles MIE must hold before interrupts are taken.
`define MIE_DEPTH       2

// Timer register byte offsets.
`define TIMER_MTIME_LO  4'h0
`define TIMER_MTIME_HI  4'h4
`define TIMER_CMP_LO    4'h8
`define TIMER_CMP_HI    4'hc

`endif

/* rtl/trap_pkg.sv */
// Shared vector types and the timer bus state enum.
package trap_pkg;

    // Data word, also used for PCs.
    typedef logic [31:0] xlen_t;

    // CSR number.
    typedef logic [11:0] csr_addr_t;

    // Interrupt or trap number.
    typedef logic [4:0] cause_t;

    // One bit per interrupt number.
    typedef logic [31:0] irq_vec_t;

    // Timer register port state.
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

endpackage

/* rtl/csr_file.sv */
// M-mode CSR file with read decode and trap, write and return update.
`timescale 1ns/1ps
`include "trap_config.svh"

module csr_file (
    input  logic                clk,
    input  logic                rst,

    // Single-cycle CSR access.
    input  logic                csr_we,
    input  trap_pkg::csr_addr_t csr_addr,
    input  trap_pkg::xlen_t     csr_wdata,
    output trap_pkg::xlen_t     csr_rdata,
    output logic                csr_exists,
    output logic                csr_rdonly,

    // Return from trap.
    input  logic                mret,

    // Exception request from the dispatcher.
    input  logic                ex_take,
    input  logic                ex_is_irq,
    input  trap_pkg::cause_t    ex_cause,
    input  trap_pkg::xlen_t     ex_epc,

    // Latched interrupt lines.
    input  trap_pkg::irq_vec_t  irq_pending,

    // State seen by the dispatcher and the fetch side.
    output logic                status_mie,
    output trap_pkg::irq_vec_t  mie_mask,
    output trap_pkg::xlen_t     mtvec,
    output trap_pkg::xlen_t     mepc
);

    // mstatus.MPIE.
    logic               status_mpie;
    // mscratch storage.
    trap_pkg::xlen_t    mscratch;
    // mcause interrupt flag.
    logic               mcause_int;
    // mcause number.
    trap_pkg::cause_t   mcause_no;

    // Assembled read views.
    trap_pkg::xlen_t    mstatus_val;
    trap_pkg::xlen_t    mcause_val;
    trap_pkg::xlen_t    mip_val;

    // Only MIE (bit 3) and MPIE (bit 7) are implemented.
    always_comb begin
        mstatus_val    = '0;
        mstatus_val[3] = status_mie;
        mstatus_val[7] = status_mpie;
    end

    assign mcause_val = {mcause_int, 26'd0, mcause_no};

    // Pending lines show only when enabled.
    assign mip_val = irq_pending & mie_mask;

    // Read decode, same cycle as the address.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        case (csr_addr)
            `CSR_MSTATUS:    csr_rdata = mstatus_val;
            `CSR_MISA: begin
                csr_rdata  = `TRAP_MISA;
                csr_rdonly = 1'b1;
            end
            `CSR_MEDELEG:    csr_rdata = '0;
            `CSR_MIDELEG:    csr_rdata = '0;
            `CSR_MIE:        csr_rdata = mie_mask;
            `CSR_MTVEC:      csr_rdata = mtvec;
            `CSR_MSTATUSH:   csr_rdata = '0;
            `CSR_MIP:        csr_rdata = mip_val;
            `CSR_MSCRATCH:   csr_rdata = mscratch;
            `CSR_MEPC:       csr_rdata = mepc;
            `CSR_MCAUSE:     csr_rdata = mcause_val;
            `CSR_MTVAL:      csr_rdata = '0;
            `CSR_MVENDORID: begin
                csr_rdata  = '0;
                csr_rdonly = 1'b1;
            end
            `CSR_MARCHID: begin
                csr_rdata  = `TRAP_MARCHID;
                csr_rdonly = 1'b1;
            end
            `CSR_MIMPID: begin
                csr_rdata  = `TRAP_MIMPID;
                csr_rdonly = 1'b1;
            end
            `CSR_MHARTID: begin
                csr_rdata  = `TRAP_MHARTID;
                csr_rdonly = 1'b1;
            end
            `CSR_MCONFIGPTR: begin
                csr_rdata  = '0;
                csr_rdonly = 1'b1;
            end
            default: begin
                // Unknown number.
                csr_rdata  = '0;
                csr_exists = 1'b0;
            end
        endcase
    end

    // Update order: exception, then CSR write, then MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie_mask    <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_no   <= '0;
        end else if (ex_take) begin
            // Save the interrupted PC and stack MIE.
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mepc        <= {ex_epc[31:1], 1'b0};
            mcause_int  <= ex_is_irq;
            mcause_no   <= ex_cause;
        end else if (csr_we) begin
            // Read-only and zero CSRs fall to default.
            case (csr_addr)
                `CSR_MSTATUS: begin
                    status_mie  <= csr_wdata[3];
                    status_mpie <= csr_wdata[7];
                end
                `CSR_MIE:      mie_mask <= csr_wdata;
                // Direct mode only, base is word aligned.
                `CSR_MTVEC:    mtvec    <= {csr_wdata[31:2], 2'b00};
                `CSR_MSCRATCH: mscratch <= csr_wdata;
                `CSR_MEPC:     mepc     <= {csr_wdata[31:1], 1'b0};
                `CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[31];
                    mcause_no  <= csr_wdata[4:0];
                end
                default: ;
            endcase
        end else if (mret) begin
            // Pop the interrupt enable.
            status_mie <= status_mpie;
        end
    end

endmodule

/* rtl/trap_dispatch.sv */
// Interrupt latch, priority pick, delayed enable and interrupt or trap choice.
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_dispatch (
    input  logic                   clk,
    input  logic                   rst,

    // Interrupt sources.
    input  logic [31:`EXT_IRQ_LO]  irq,
    input  logic                   timer_irq,

    // Retiring instruction.
    input  logic                   retire_valid,
    input  logic                   retire_trap,
    input  trap_pkg::xlen_t        retire_pc,
    input  trap_pkg::cause_t       retire_cause,

    // Enables from the CSR file.
    input  logic                   status_mie,
    input  trap_pkg::irq_vec_t     mie_mask,

    // Latched lines.
    output trap_pkg::irq_vec_t     irq_pending,

    // Exception request.
    output logic                   ex_take,
    output logic                   ex_is_irq,
    output trap_pkg::cause_t       ex_cause,
    output trap_pkg::xlen_t        ex_epc
);

    // Line vector before the latch.
    trap_pkg::irq_vec_t      irq_next;
    // Enabled and pending lines.
    trap_pkg::irq_vec_t      irq_active;
    // Lowest active number.
    trap_pkg::cause_t        irq_cause;
    // Past values of mstatus.MIE.
    logic [`MIE_DEPTH-1:0]   mie_hist;
    // MIE held long enough.
    logic                    irq_en;
    // Interrupt wins this cycle.
    logic                    irq_go;

    // Unused numbers stay zero.
    always_comb begin
        irq_next                 = '0;
        irq_next[31:`EXT_IRQ_LO] = irq;
        irq_next[`TIMER_IRQ]     = timer_irq;
    end

    // Latch lines and track the enable history.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
            mie_hist    <= '0;
        end else begin
            irq_pending <= irq_next;
            mie_hist    <= {mie_hist[`MIE_DEPTH-2:0], status_mie};
        end
    end

    assign irq_active = irq_pending & mie_mask;

    // Scan down so the lowest set bit is left.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_active[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    assign irq_en = (&mie_hist) && status_mie;
    assign irq_go = irq_en && (|irq_active) && retire_valid;

    // Interrupt before trap, nothing taken in reset.
    assign ex_take   = !rst && (irq_go || (retire_valid && retire_trap));
    assign ex_is_irq = irq_go;
    assign ex_cause  = irq_go ? irq_cause : retire_cause;
    assign ex_epc    = {retire_pc[31:1], 1'b0};

endmodule

/* rtl/machine_timer.sv */
// Wishbone classic timer slave with mtime, mtimecmp and the timer interrupt.
`timescale 1ns/1ps
`include "trap_config.svh"

module machine_timer (
    input  logic             clk,
    input  logic             rst,

    // Wishbone classic slave.
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [3:0]       wb_adr,
    input  trap_pkg::xlen_t  wb_dat_w,
    output trap_pkg::xlen_t  wb_dat_r,
    output logic             wb_ack,

    // Compare match.
    output logic             timer_irq
);

    // Free-running cycle counter.
    logic [63:0]           mtime;
    // Compare value.
    logic [63:0]           mtimecmp;
    // Bus handshake state.
    trap_pkg::wb_state_e   state;
    // New request this cycle.
    logic                  req;

    // Only accept in idle so each request acts once.
    assign req = wb_cyc && wb_stb && (state == trap_pkg::WB_IDLE);

    // One acknowledge cycle after each request.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= trap_pkg::WB_IDLE;
        end else if (req) begin
            state <= trap_pkg::WB_ACK;
        end else begin
            state <= trap_pkg::WB_IDLE;
        end
    end

    assign wb_ack = (state == trap_pkg::WB_ACK);

    // Counter and compare registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 64'd1;
            if (req && wb_we) begin
                case (wb_adr)
                    // A write replaces the count.
                    `TIMER_MTIME_LO: mtime[31:0]     <= wb_dat_w;
                    `TIMER_MTIME_HI: mtime[63:32]    <= wb_dat_w;
                    `TIMER_CMP_LO:   mtimecmp[31:0]  <= wb_dat_w;
                    `TIMER_CMP_HI:   mtimecmp[63:32] <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // Read data captured with the request, shown during ack.
    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_adr)
                `TIMER_MTIME_LO: wb_dat_r <= mtime[31:0];
                `TIMER_MTIME_HI: wb_dat_r <= mtime[63:32];
                `TIMER_CMP_LO:   wb_dat_r <= mtimecmp[31:0];
                `TIMER_CMP_HI:   wb_dat_r <= mtimecmp[63:32];
                default:         wb_dat_r <= '0;
            endcase
        end
    end

    // Level interrupt while at or past compare.
    assign timer_irq = (mtime >= mtimecmp);

endmodule

/* rtl/trap_unit.sv */
// Trap controller top level joining CSR file, dispatcher and machine timer.
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_unit (
    input  logic                   clk,
    input  logic                   rst,

    // CSR access.
    input  logic                   csr_we,
    input  trap_pkg::csr_addr_t    csr_addr,
    input  trap_pkg::xlen_t        csr_wdata,
    output trap_pkg::xlen_t        csr_rdata,
    output logic                   csr_exists,
    output logic                   csr_rdonly,

    // Retire port.
    input  logic                   retire_valid,
    input  logic                   retire_trap,
    input  trap_pkg::xlen_t        retire_pc,
    input  trap_pkg::cause_t       retire_cause,

    input  logic                   mret,

    // External interrupt lines.
    input  logic [31:`EXT_IRQ_LO]  irq,

    // Timer register port.
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [3:0]             wb_adr,
    input  trap_pkg::xlen_t        wb_dat_w,
    output trap_pkg::xlen_t        wb_dat_r,
    output logic                   wb_ack,

    // Control transfer outputs.
    output logic                   exception,
    output trap_pkg::xlen_t        tvec,
    output trap_pkg::xlen_t        ret_epc
);

    trap_pkg::irq_vec_t  irq_pending;
    trap_pkg::irq_vec_t  mie_mask;
    logic                status_mie;
    logic                ex_is_irq;
    trap_pkg::cause_t    ex_cause;
    trap_pkg::xlen_t     ex_epc;
    logic                timer_irq;

    // Exception output doubles as the take strobe.
    csr_file csr_file_i (
        .clk         (clk),
        .rst         (rst),
        .csr_we      (csr_we),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .mret        (mret),
        .ex_take     (exception),
        .ex_is_irq   (ex_is_irq),
        .ex_cause    (ex_cause),
        .ex_epc      (ex_epc),
        .irq_pending (irq_pending),
        .status_mie  (status_mie),
        .mie_mask    (mie_mask),
        .mtvec       (tvec),
        .mepc        (ret_epc)
    );

    trap_dispatch trap_dispatch_i (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .timer_irq    (timer_irq),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .retire_pc    (retire_pc),
        .retire_cause (retire_cause),
        .status_mie   (status_mie),
        .mie_mask     (mie_mask),
        .irq_pending  (irq_pending),
        .ex_take      (exception),
        .ex_is_irq    (ex_is_irq),
        .ex_cause     (ex_cause),
        .ex_epc       (ex_epc)
    );

    machine_timer machine_timer_i (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .timer_irq (timer_irq)
    );

endmodule

/* sim/trap_unit_assertions.sv */
// Bound concurrent checks on the trap unit handshake and exception strobe.
`timescale 1ns/1ps

module trap_unit_assertions (
    input logic clk,
    input logic rst,
    input logic wb_ack,
    input logic exception,
    input logic retire_valid
);

    // Number of failed assertions.
    int unsigned error_count = 0;

    // Acknowledge is a single-cycle pulse.
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held for more than one cycle");
            error_count++;
        end

    // Only a retiring instruction can take an exception.
    exc_needs_retire: assert property (@(posedge clk) exception |-> retire_valid)
        else begin
            $error("exception raised without retire_valid");
            error_count++;
        end

    // Quiet while in reset.
    exc_low_in_reset: assert property (@(posedge clk) rst |-> !exception)
        else begin
            $error("exception high during reset");
            error_count++;
        end

endmodule

bind trap_unit trap_unit_assertions assertions_i (
    .clk          (clk),
    .rst          (rst),
    .wb_ack       (wb_ack),
    .exception    (exception),
    .retire_valid (retire_valid)
);

/* sim/trap_unit_tb.sv */
// Trap unit testbench with clock, reset, stimulus table, loop and checks.
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_unit_tb;

    // Row operations.
    localparam logic [3:0] OP_CSR_WR = 0, OP_CSR_RD = 1, OP_FLAGS = 2, OP_RETIRE = 3;
    localparam logic [3:0] OP_WAIT_EXC = 4, OP_MRET = 5, OP_IRQ = 6, OP_OUT = 7;
    localparam logic [3:0] OP_TMR_WR = 8, OP_TMR_RD = 9, OP_TMR_TIME = 10;
    // Wait limit in cycles.
    localparam int TIMEOUT = 64;

    logic clk, rst, csr_we, csr_exists, csr_rdonly, retire_valid, retire_trap, mret;
    logic wb_cyc, wb_stb, wb_we, wb_ack, exception;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata, csr_rdata, retire_pc, wb_dat_w, wb_dat_r, tvec, ret_epc;
    logic [4:0] retire_cause;
    logic [31:16] irq;
    logic [3:0] wb_adr;

    // Rows are {op, addr, data, expected}.
    logic [79:0] rows[$];
    logic [3:0] op;
    logic [11:0] adr;
    logic [31:0] dat, exp_val, rd, last_time, bound;

    trap_unit dut_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
        if (got !== expv) begin
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, expv);
            fail_run("value mismatch");
        end
    endtask

    task automatic add(input logic [3:0] o, input logic [11:0] a, input logic [31:0] d,
                       input logic [31:0] e);
        rows.push_back({o, a, d, e});
    endtask

    // One Wishbone classic transfer, held until ack.
    task automatic wb_access(input logic we, input logic [3:0] a, input logic [31:0] d,
                             output logic [31:0] r);
        int cnt;
        cnt = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= a;
        wb_dat_w <= d;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("timer port never acknowledged");
        end while (!wb_ack);
        r = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    // Hold a retiring instruction until an exception is taken.
    task automatic wait_exception(input logic [31:0] pc);
        int cnt;
        cnt = 0;
        @(posedge clk);
        retire_valid <= 1'b1;
        retire_pc <= pc;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("exception never raised");
        end while (!exception);
        @(posedge clk);
        retire_valid <= 1'b0;
    endtask

    // Watch the bound checker.
    always @(negedge clk) begin
        if (dut_i.assertions_i.error_count != 0) begin
            fail_run("a bound assertion failed");
        end
    end

    initial begin
        // A trapping retire is held through reset.
        {rst, retire_valid, retire_trap} = 3'b111;
        {csr_we, mret, wb_cyc, wb_stb, wb_we} = '0;
        csr_addr = '0;
        csr_wdata = '0;
        retire_pc = '0;
        retire_cause = '0;
        irq = '0;
        wb_adr = '0;
        wb_dat_w = '0;
        last_time = '0;

        // Identity, zero and unknown CSRs.
        add(OP_CSR_RD, `CSR_MISA, 0, `TRAP_MISA);
        add(OP_FLAGS, `CSR_MISA, 0, 32'd3);
        add(OP_CSR_RD, `CSR_MARCHID, 0, `TRAP_MARCHID);
        add(OP_CSR_RD, `CSR_MIMPID, 0, `TRAP_MIMPID);
        add(OP_CSR_RD, `CSR_MHARTID, 0, `TRAP_MHARTID);
        add(OP_CSR_RD, `CSR_MVENDORID, 0, 0);
        add(OP_FLAGS, `CSR_MCONFIGPTR, 0, 32'd3);
        add(OP_CSR_RD, `CSR_MEDELEG, 0, 0);
        add(OP_CSR_RD, `CSR_MTVAL, 0, 0);
        add(OP_FLAGS, `CSR_MSTATUSH, 0, 32'd2);
        add(OP_FLAGS, 12'h7c0, 0, 32'd0);
        add(OP_CSR_WR, `CSR_MARCHID, 32'h1234, 0);
        add(OP_CSR_RD, `CSR_MARCHID, 0, `TRAP_MARCHID);
        add(OP_CSR_WR, `CSR_MISA, 32'h0, 0);
        add(OP_CSR_RD, `CSR_MISA, 0, `TRAP_MISA);
        // Plain read-write registers, mtvec word aligned.
        add(OP_CSR_WR, `CSR_MSCRATCH, 32'hdead_beef, 0);
        add(OP_CSR_RD, `CSR_MSCRATCH, 0, 32'hdead_beef);
        add(OP_CSR_WR, `CSR_MTVEC, 32'h8000_0103, 0);
        add(OP_CSR_RD, `CSR_MTVEC, 0, 32'h8000_0100);
        add(OP_OUT, 12'd0, 0, 32'h8000_0100);
        add(OP_CSR_WR, `CSR_MIE, 32'h0024_0080, 0);
        add(OP_CSR_RD, `CSR_MIE, 0, 32'h0024_0080);
        // Synchronous trap, then MRET.
        add(OP_CSR_WR, `CSR_MSTATUS, 32'h8, 0);
        add(OP_CSR_RD, `CSR_MSTATUS, 0, 32'h8);
        add(OP_RETIRE, 12'd2, 32'h0000_2344, 0);
        add(OP_CSR_RD, `CSR_MEPC, 0, 32'h0000_2344);
        add(OP_CSR_RD, `CSR_MCAUSE, 0, 32'd2);
        add(OP_CSR_RD, `CSR_MSTATUS, 0, 32'h80);
        add(OP_MRET, 0, 0, 0);
        add(OP_CSR_RD, `CSR_MSTATUS, 0, 32'h88);
        add(OP_OUT, 12'd1, 0, 32'h0000_2344);
        // Two external lines at once, line 18 wins.
        add(OP_CSR_WR, `CSR_MIE, 32'h0024_0000, 0);
        add(OP_CSR_WR, `CSR_MSTATUS, 32'h8, 0);
        add(OP_IRQ, 0, 32'h0024_0000, 0);
        add(OP_WAIT_EXC, 0, 32'h0000_3000, 0);
        add(OP_CSR_RD, `CSR_MCAUSE, 0, 32'h8000_0012);
        add(OP_CSR_RD, `CSR_MSTATUS, 0, 32'h80);
        add(OP_CSR_RD, `CSR_MEPC, 0, 32'h0000_3000);
        add(OP_IRQ, 0, 32'h0, 0);
        // Timer registers over Wishbone.
        add(OP_TMR_RD, `TIMER_CMP_LO, 0, 32'hffff_ffff);
        add(OP_TMR_WR, `TIMER_CMP_HI, 32'd5, 0);
        add(OP_TMR_RD, `TIMER_CMP_HI, 0, 32'd5);
        add(OP_TMR_WR, `TIMER_MTIME_LO, 32'h1000, 0);
        add(OP_TMR_TIME, `TIMER_MTIME_LO, 0, 32'h1000);
        add(OP_TMR_TIME, `TIMER_MTIME_LO, 0, 32'h1000);
        add(OP_TMR_RD, `TIMER_MTIME_HI, 0, 32'd0);
        // Timer interrupt once compare drops below mtime.
        add(OP_CSR_WR, `CSR_MIE, 32'h80, 0);
        add(OP_CSR_WR, `CSR_MSTATUS, 32'h8, 0);
        add(OP_TMR_WR, `TIMER_CMP_HI, 32'd0, 0);
        add(OP_TMR_WR, `TIMER_CMP_LO, 32'h10, 0);
        add(OP_WAIT_EXC, 0, 32'h0000_4000, 0);
        add(OP_CSR_RD, `CSR_MCAUSE, 0, 32'h8000_0007);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        retire_valid <= 1'b0;
        retire_trap <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            {op, adr, dat, exp_val} = rows[i];
            case (op)
                OP_CSR_WR: begin
                    @(posedge clk);
                    csr_we <= 1'b1;
                    csr_addr <= adr;
                    csr_wdata <= dat;
                    @(posedge clk);
                    csr_we <= 1'b0;
                end
                OP_CSR_RD, OP_FLAGS: begin
                    @(posedge clk);
                    csr_addr <= adr;
                    @(negedge clk);
                    if (op == OP_FLAGS) check("csr_exists_rdonly", {csr_exists, csr_rdonly},
                                              exp_val);
                    else check("csr_rdata", csr_rdata, exp_val);
                end
                OP_RETIRE: begin
                    @(posedge clk);
                    retire_valid <= 1'b1;
                    retire_trap <= 1'b1;
                    retire_cause <= adr[4:0];
                    retire_pc <= dat;
                    // Trap is flagged in the retire cycle itself.
                    @(negedge clk);
                    check("exception", exception, 1);
                    @(posedge clk);
                    retire_valid <= 1'b0;
                    retire_trap <= 1'b0;
                end
                OP_WAIT_EXC: wait_exception(dat);
                OP_MRET: begin
                    @(posedge clk);
                    mret <= 1'b1;
                    @(posedge clk);
                    mret <= 1'b0;
                end
                OP_IRQ: begin
                    @(posedge clk);
                    irq <= dat[31:16];
                end
                OP_OUT: begin
                    @(negedge clk);
                    if (adr == 0) check("tvec", tvec, exp_val);
                    else check("ret_epc", ret_epc, exp_val);
                end
                OP_TMR_WR: wb_access(1'b1, adr[3:0], dat, rd);
                OP_TMR_RD: begin
                    wb_access(1'b0, adr[3:0], 0, rd);
                    check("wb_dat_r", rd, exp_val);
                end
                default: begin
                    // Counter must not fall below the bound or the last read.
                    wb_access(1'b0, adr[3:0], 0, rd);
                    bound = (exp_val > last_time) ? exp_val : last_time;
                    check("mtime_lo", (rd >= bound) ? bound : rd, bound);
                    last_time = rd;
                end
            endcase
        end

        if (dut_i.assertions_i.error_count != 0) begin
            fail_run("a bound assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+include
rtl/trap_pkg.sv
rtl/csr_file.sv
rtl/trap_dispatch.sv
rtl/machine_timer.sv
rtl/trap_unit.sv
sim/trap_unit_assertions.sv
sim/trap_unit_tb.sv
